//--- logic/zx_bus_pkg.sv
`default_nettype none

// ==================================================
// CPU bus and SDRAM request port types
// ==================================================
package zx_bus_pkg;

	localparam int RAM_ADDR_W = 24;	// SDRAM byte address width

	// One CPU bus cycle as seen at the pins, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;	// CPU data out
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} cpu_bus_t;

	// Toggle handshake toward the SDRAM controller
	typedef struct packed {
		logic                  req;	// Flips once per request
		logic                  we;
		logic [RAM_ADDR_W-1:0] addr;	// Byte address, bit 0 picks the byte lane
		logic [7:0]            data;
	} sdram_req_t;

endpackage

`default_nettype wire

//--- logic/zx_mem_pkg.sv
`default_nettype none

// ==================================================
// Memory modes, paging state and SDRAM layout
// ==================================================
package zx_mem_pkg;

	// Machine type, same codes as the memory menu
	typedef enum logic [2:0] {
		MODE_128K  = 3'd0,
		MODE_P1024 = 3'd1,
		MODE_48K   = 3'd3,
		MODE_PLUS3 = 3'd4
	} mem_mode_e;

	typedef struct packed {
		logic [7:0] reg_7ffd;	// RAM bank, screen, ROM bit, lock
		logic [7:0] reg_1ffd;	// +3 special mode and high ROM bit
		logic [7:0] reg_eff7;	// Pentagon 1024 control
		logic [2:0] ext_bank;	// Pentagon bank bits above 7FFD[2:0]
		logic       zx48;
		logic       plus3;
	} paging_t;

	localparam int BANK_SIZE_W = 14;	// 16K page offset

	// ROM pages live above the RAM banks
	localparam logic [23:0] ROM_BASE       = 24'h150000;
	localparam logic [3:0]  ROM_PAGE_128   = 4'd6;	// 128K editor, +1 for 48K BASIC
	localparam logic [3:0]  ROM_PAGE_PLUS3 = 4'd8;	// Four +3 ROMs from here
	localparam logic [3:0]  ROM_PAGE_48K   = 4'd13;

	// Fixed RAM banks behind 4000 and 8000
	localparam logic [5:0] BANK_SLOT1 = 6'd5;
	localparam logic [5:0] BANK_SLOT2 = 6'd2;

endpackage

`default_nettype wire

//--- logic/paging_regs.sv
`timescale 1ns/1ps
`default_nettype none

module paging_regs
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  wire            clk_sys,
	input  wire            reset,
	input  wire cpu_bus_t  cpu,
	input  wire mem_mode_e mem_mode,
	output paging_t        paging
);

	logic io_wr;		// I/O write cycle, M1 excluded
	logic io_wr_d;
	logic wr_edge;
	logic p1024;		// Pentagon 1024 machine
	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_eff7;

	// ==================================================
	// Port decode
	// ==================================================
	assign io_wr   = cpu.iorq & cpu.wr & ~cpu.m1;
	assign wr_edge = io_wr & ~io_wr_d;	// First cycle of the write only

	assign sel_7ffd = ~cpu.addr[15] & ~cpu.addr[1] &
		(cpu.addr[14] | paging.plus3);

	// 1FFD also matches the loose 7FFD decode on +3, so it is checked first
	assign sel_1ffd = paging.plus3 & cpu.addr[12] &
		~cpu.addr[15] & ~cpu.addr[14] & ~cpu.addr[13] & ~cpu.addr[1];

	assign sel_eff7 = p1024 & (&cpu.addr[15:13]) & ~cpu.addr[12] & ~cpu.addr[3];

	// 48K never pages, Pentagon honours bit 5 only in 128K-compatible mode
	assign locked = paging.zx48 |
		(~p1024 & paging.reg_7ffd[5]) |
		(p1024 & paging.reg_eff7[2] & paging.reg_7ffd[5]);

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_wr_d <= 1'b0;
		else
			io_wr_d <= io_wr;
	end

	// ==================================================
	// Paging registers
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			paging.reg_7ffd <= 8'h00;
			paging.reg_1ffd <= 8'h00;
			paging.reg_eff7 <= 8'h00;
			paging.ext_bank <= 3'd0;
			paging.zx48     <= (mem_mode == MODE_48K);	// Machine type taken during reset
			paging.plus3    <= (mem_mode == MODE_PLUS3);
			p1024           <= (mem_mode == MODE_P1024);
		end else begin
			if (wr_edge && !locked) begin
				if (sel_1ffd) begin
					paging.reg_1ffd <= cpu.dout;
				end else if (sel_7ffd) begin
					paging.reg_7ffd <= cpu.dout;
					// Extra bank bits ride on D5, D7, D6
					if (p1024 && !paging.reg_eff7[2])
						paging.ext_bank <= {cpu.dout[5], cpu.dout[7:6]};
				end
			end

			if (wr_edge && sel_eff7)
				paging.reg_eff7 <= cpu.dout;	// Not subject to the lock
		end
	end

endmodule

`default_nettype wire

//--- logic/addr_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module addr_mapper
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
(
	input  wire cpu_bus_t         cpu,
	input  wire paging_t          paging,
	output logic [RAM_ADDR_W-1:0] ram_addr,
	output logic                  ram_rd,
	output logic                  ram_we
);

	logic                   special;	// +3 all-RAM mode
	logic [1:0]             slot;
	logic [BANK_SIZE_W-1:0] offset;
	logic [3:0]             rom_page;
	logic [5:0]             bank;

	assign special = paging.reg_1ffd[0];
	assign slot    = cpu.addr[15:14];
	assign offset  = cpu.addr[BANK_SIZE_W-1:0];

	// ==================================================
	// ROM page select
	// ==================================================
	always_comb begin
		if (paging.zx48)
			rom_page = ROM_PAGE_48K;
		else if (paging.plus3)
			rom_page = ROM_PAGE_PLUS3 + {2'b00, paging.reg_1ffd[2], paging.reg_7ffd[4]};
		else
			rom_page = ROM_PAGE_128 + {3'b000, paging.reg_7ffd[4]};
	end

	// ==================================================
	// RAM bank per slot
	// ==================================================
	always_comb begin
		bank = 6'd0;
		if (special) begin
			case (paging.reg_1ffd[2:1])
				2'b00: bank = {4'd0, slot};	// 0,1,2,3
				2'b01: bank = {4'd1, slot};	// 4,5,6,7
				2'b10: bank = (slot == 2'd3) ? 6'd3 : {4'd1, slot};	// 4,5,6,3
				default: begin	// 4,7,6,3
					if (slot == 2'd1)
						bank = 6'd7;
					else if (slot == 2'd3)
						bank = 6'd3;
					else
						bank = {4'd1, slot};
				end
			endcase
		end else begin
			case (slot)
				2'd1:    bank = BANK_SLOT1;
				2'd2:    bank = BANK_SLOT2;
				2'd3:    bank = {paging.ext_bank, paging.reg_7ffd[2:0]};
				default: bank = 6'd0;	// ROM slot, bank not used
			endcase
		end
	end

	always_comb begin
		if (!special && slot == 2'd0)
			ram_addr = ROM_BASE + {6'd0, rom_page, offset};
		else
			ram_addr = {4'd0, bank, offset};	// Bank n at n * 16K
	end

	assign ram_rd = cpu.mreq & cpu.rd;
	// ROM is write protected unless it is RAM in special mode
	assign ram_we = cpu.mreq & cpu.wr & (special | (slot != 2'd0));

endmodule

`default_nettype wire

//--- logic/sdram_port.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_port
	import zx_bus_pkg::*;
#(
	parameter int RD_SETTLE = 2	// Read strobe delay before the request, 1 to 3
)(
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire cpu_bus_t        cpu,
	input  wire [RAM_ADDR_W-1:0] ram_addr,
	input  wire                  ram_rd,
	input  wire                  ram_we,
	output sdram_req_t           sdram,
	input  wire                  sdram_ack,
	input  wire [15:0]           sdram_q,
	output logic [7:0]           ram_dout,
	output logic                 ram_ready
);

	logic [RD_SETTLE-1:0]  rd_pipe;
	logic [RD_SETTLE:0]    rd_hist;	// Bit 0 is the live strobe
	logic                  we_d;
	logic                  new_rd;
	logic                  new_we;
	logic                  new_req;
	logic                  req_r;
	logic                  we_r;
	logic [RAM_ADDR_W-1:0] addr_r;
	logic [7:0]            data_r;

	// ==================================================
	// Strobe edge detection
	// ==================================================
	assign rd_hist = {rd_pipe, ram_rd};
	assign new_rd  = rd_hist[RD_SETTLE-1] & ~rd_hist[RD_SETTLE];	// Delayed rising edge
	assign new_we  = ram_we & ~we_d;
	assign new_req = new_rd | new_we;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rd_pipe <= '0;
			we_d    <= 1'b0;
		end else begin
			rd_pipe <= rd_hist[RD_SETTLE-1:0];
			we_d    <= ram_we;
		end
	end

	// ==================================================
	// Toggle request
	// ==================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			req_r <= 1'b0;
			we_r  <= 1'b0;
		end else if (new_req) begin
			req_r <= ~req_r;
			we_r  <= ram_we;
		end
	end

	// Address and data follow the request edge
	always_ff @(posedge clk_sys) begin
		if (new_req) begin
			addr_r <= ram_addr;
			data_r <= cpu.dout;
		end
	end

	assign sdram = '{req: req_r, we: we_r, addr: addr_r, data: data_r};

	assign ram_dout  = addr_r[0] ? sdram_q[15:8] : sdram_q[7:0];	// Byte lane of the word
	assign ram_ready = (sdram_ack == req_r) & ~new_req;

endmodule

`default_nettype wire

//--- logic/zx_memory_top.sv
`timescale 1ns/1ps
`default_nettype none

module zx_memory_top
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
#(
	parameter int RD_SETTLE = 2
)(
	input  wire             clk_sys,
	input  wire             reset,
	input  wire cpu_bus_t   cpu,
	input  wire mem_mode_e  mem_mode,
	output wire sdram_req_t sdram,
	input  wire             sdram_ack,
	input  wire [15:0]      sdram_q,
	output wire [7:0]       ram_dout,
	output wire             ram_ready
);

	paging_t               paging;
	logic [RAM_ADDR_W-1:0] ram_addr;
	logic                  ram_rd;
	logic                  ram_we;

	// Port writes update the paging state
	paging_regs u_paging_regs (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu      (cpu),
		.mem_mode (mem_mode),
		.paging   (paging)
	);

	addr_mapper u_addr_mapper (
		.cpu      (cpu),
		.paging   (paging),
		.ram_addr (ram_addr),
		.ram_rd   (ram_rd),
		.ram_we   (ram_we)
	);

	// One outstanding SDRAM access at a time
	sdram_port #(
		.RD_SETTLE (RD_SETTLE)
	) u_sdram_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.ram_addr  (ram_addr),
		.ram_rd    (ram_rd),
		.ram_we    (ram_we),
		.sdram     (sdram),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q),
		.ram_dout  (ram_dout),
		.ram_ready (ram_ready)
	);

endmodule

`default_nettype wire

//--- sim/zx_memory_sva.sv
`timescale 1ns/1ps
`default_nettype none

module zx_memory_sva
	import zx_bus_pkg::*;
(
	input wire             clk_sys,
	input wire             reset,
	input wire sdram_req_t sdram,
	input wire             sdram_ack,
	input wire             ram_we,
	input wire             ram_ready,
	input wire             new_req
);

	int failures = 0;	// Summed into the testbench result

	// ==================================================
	// Toggle handshake
	// ==================================================
	a_req_held: assert property (@(posedge clk_sys) disable iff (reset)
		(sdram.req != sdram_ack) |=> $stable(sdram.req))
		else begin
			$error("req toggled while a request was outstanding");
			failures++;
		end

	// A second strobe edge must wait for the ack
	a_one_outstanding: assert property (@(posedge clk_sys) disable iff (reset)
		new_req |-> (sdram.req == sdram_ack))
		else begin
			$error("new CPU strobe while a request was outstanding");
			failures++;
		end

	a_write_latency: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ram_we) |=> $changed(sdram.req))
		else begin
			$error("write request not issued one cycle after the strobe");
			failures++;
		end

	// ==================================================
	// Reset state
	// ==================================================
	a_reset_clear: assert property (@(posedge clk_sys)
		reset |=> (!sdram.req && !sdram.we))
		else begin
			$error("req or we not cleared by reset");
			failures++;
		end

	a_ready_after_reset: assert property (@(posedge clk_sys)
		$fell(reset) |-> ram_ready)
		else begin
			$error("ram_ready low when reset was released");
			failures++;
		end

endmodule

bind sdram_port zx_memory_sva u_sva (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.sdram     (sdram),
	.sdram_ack (sdram_ack),
	.ram_we    (ram_we),
	.ram_ready (ram_ready),
	.new_req   (new_req)
);

`default_nettype wire

//--- sim/tb_zx_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_zx_memory
	import zx_bus_pkg::*;
	import zx_mem_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int RD_SETTLE  = 2;
	localparam int MAX_ACK    = 6;
	localparam int NUM_TXN    = 110;	// Memory and port cycles, with margin
	localparam int WATCHDOG_CYCLES = 12 * 18 + NUM_TXN * (RD_SETTLE + MAX_ACK + 4);
	localparam cpu_bus_t CPU_IDLE = '0;

	// +3 special banks per 1FFD[2:1], slot 0 of setting 00 in the low bits
	localparam logic [47:0] SPECIAL_MAP =
		{3'd3, 3'd6, 3'd7, 3'd4, 3'd3, 3'd6, 3'd5, 3'd4, 3'd7, 3'd6, 3'd5, 3'd4, 3'd3, 3'd2, 3'd1, 3'd0};

	logic        clk_sys = 1'b0;
	logic        reset;
	cpu_bus_t    cpu;
	mem_mode_e   mem_mode;
	sdram_req_t  sdram;
	logic        sdram_ack = 1'b0;
	logic [15:0] sdram_q = 16'h0000;
	logic [7:0]  ram_dout;
	logic        ram_ready;

	logic [7:0]  sdram_mem [int];	// Bytes written through the port
	int          seed = 32'h31d7_7121;
	int          errors = 0;
	int          checks = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          errors_at_start;
	string       test_name;

	// Reference paging state
	mem_mode_e   ref_mode;
	logic [7:0]  ref_7ffd;
	logic [7:0]  ref_1ffd;
	logic [7:0]  ref_eff7;
	logic [2:0]  ref_ext;

	zx_memory_top #(.RD_SETTLE(RD_SETTLE)) dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu       (cpu),
		.mem_mode  (mem_mode),
		.sdram     (sdram),
		.sdram_ack (sdram_ack),
		.sdram_q   (sdram_q),
		.ram_dout  (ram_dout),
		.ram_ready (ram_ready)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	function automatic logic [7:0] fill_byte(input logic [23:0] a);
		return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;	// Never written bytes
	endfunction

	function automatic logic [7:0] stored_byte(input logic [23:0] a);
		return sdram_mem.exists(int'(a)) ? sdram_mem[int'(a)] : fill_byte(a);
	endfunction

	// ==================================================
	// SDRAM controller model
	// ==================================================
	always begin : sdram_model
		int delay;
		@(negedge clk_sys);
		if (reset) begin
			sdram_ack = 1'b0;
		end else if (sdram.req != sdram_ack) begin
			delay = 1 + ($unsigned($random(seed)) % MAX_ACK);
			repeat (delay - 1) @(negedge clk_sys);
			if (sdram.we)
				sdram_mem[int'(sdram.addr)] = sdram.data;
			else
				sdram_q = {stored_byte(sdram.addr | 24'd1), stored_byte(sdram.addr & ~24'd1)};
			sdram_ack = sdram.req;	// Word valid with the ack
		end
	end

	// ==================================================
	// Reference paging model
	// ==================================================
	function automatic logic [23:0] expected_addr(input logic [15:0] a);
		int page;
		int bank;
		bank = 0;
		if (ref_1ffd[0]) begin
			bank = int'(SPECIAL_MAP[(int'(ref_1ffd[2:1]) * 4 + int'(a[15:14])) * 3 +: 3]);
		end else if (a[15:14] == 2'd0) begin
			case (ref_mode)
				MODE_48K:   page = 13;
				MODE_PLUS3: page = 8 + 2 * int'(ref_1ffd[2]) + int'(ref_7ffd[4]);
				default:    page = 6 + int'(ref_7ffd[4]);
			endcase
			return 24'(int'(ROM_BASE) + page * 16384 + int'(a[13:0]));
		end else begin
			case (a[15:14])
				2'd1:    bank = 5;
				2'd2:    bank = 2;
				default: bank = int'(ref_ext) * 8 + int'(ref_7ffd[2:0]);
			endcase
		end
		return 24'(bank * 16384 + int'(a[13:0]));
	endfunction

	function automatic void model_port_write(input logic [15:0] port, input logic [7:0] data);
		logic locked;
		locked = (ref_mode == MODE_48K) ||
			(ref_7ffd[5] && (ref_mode != MODE_P1024 || ref_eff7[2]));
		if (port == 16'h1FFD && ref_mode == MODE_PLUS3 && !locked) begin
			ref_1ffd = data;
		end else if (port == 16'h7FFD && !locked) begin
			if (ref_mode == MODE_P1024 && !ref_eff7[2])
				ref_ext = {data[5], data[7], data[6]};
			ref_7ffd = data;
		end
		if (port == 16'hEFF7 && ref_mode == MODE_P1024)
			ref_eff7 = data;
	endfunction

	// ==================================================
	// Bus tasks and checks
	// ==================================================
	task automatic check_value(input string what, input logic [23:0] exp, input logic [23:0] act);
		checks++;
		assert (exp === act) else begin
			$display("Mismatch %s: %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic apply_reset(input mem_mode_e mode);
		@(negedge clk_sys);
		reset = 1'b1;
		mem_mode = mode;
		cpu = CPU_IDLE;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		ref_mode = mode;
		ref_7ffd = 8'h00;
		ref_1ffd = 8'h00;
		ref_eff7 = 8'h00;
		ref_ext = 3'd0;
	endtask

	task automatic io_write(input logic [15:0] port, input logic [7:0] data);
		@(negedge clk_sys);
		cpu = '{addr: port, dout: data, mreq: 1'b0, iorq: 1'b1, rd: 1'b0, wr: 1'b1, m1: 1'b0};
		@(negedge clk_sys);
		cpu = CPU_IDLE;
		@(negedge clk_sys);
		model_port_write(port, data);
	endtask

	// Strobes held until the access completes
	task automatic mem_cycle(input logic [15:0] a, input logic write, input logic [7:0] data);
		logic req_before;
		req_before = sdram.req;
		@(negedge clk_sys);
		cpu = '{addr: a, dout: data, mreq: 1'b1, iorq: 1'b0, rd: ~write, wr: write, m1: 1'b0};
		while (sdram.req == req_before)
			@(negedge clk_sys);
		check_value("address", expected_addr(a), sdram.addr);
		check_value("direction", {23'd0, write}, {23'd0, sdram.we});
		while (!ram_ready)
			@(negedge clk_sys);
		cpu = CPU_IDLE;
	endtask

	task automatic mem_read(input logic [15:0] a, input logic [7:0] exp_data);
		mem_cycle(a, 1'b0, 8'h00);
		check_value("read data", {16'd0, exp_data}, {16'd0, ram_dout});
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%s: ok", test_name);
		end else begin
			tests_failed++;
			$display("%s: failed, %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// ==================================================
	// Tests
	// ==================================================
	initial begin : main
		mem_mode_e   modes [4];
		logic [7:0]  pent_data [3];
		logic [15:0] a;
		logic [7:0]  d;
		logic        req_before;
		modes = '{MODE_128K, MODE_P1024, MODE_48K, MODE_PLUS3};
		pent_data = '{8'hE5, 8'h24, 8'h42};
		reset = 1'b1;
		cpu = CPU_IDLE;
		mem_mode = MODE_128K;

		start_test("reset_map");
		foreach (modes[i]) begin
			apply_reset(modes[i]);
			mem_read(16'h0000, fill_byte(expected_addr(16'h0000)));
			mem_read(16'hC000, fill_byte(expected_addr(16'hC000)));
		end
		finish_test();

		start_test("write_readback");
		apply_reset(MODE_128K);
		for (int k = 0; k < 8; k++) begin
			a = 16'hC000 | 16'($random(seed) & 32'h3FFF);
			d = 8'($random(seed));
			io_write(16'h7FFD, 8'(k));
			mem_cycle(a, 1'b1, d);
			mem_read(a, d);
		end
		finish_test();

		start_test("paging_lock");
		apply_reset(MODE_128K);
		io_write(16'h7FFD, 8'h23);	// Bank 3 and lock
		io_write(16'h7FFD, 8'h06);
		mem_read(16'hC010, stored_byte(expected_addr(16'hC010)));
		apply_reset(MODE_128K);
		io_write(16'h7FFD, 8'h06);
		mem_read(16'hC010, stored_byte(expected_addr(16'hC010)));
		apply_reset(MODE_48K);
		io_write(16'h7FFD, 8'h17);
		mem_read(16'hC010, stored_byte(expected_addr(16'hC010)));
		mem_read(16'h0010, fill_byte(expected_addr(16'h0010)));
		finish_test();

		start_test("plus3_special");
		apply_reset(MODE_PLUS3);
		for (int k = 0; k < 4; k++) begin
			io_write(16'h1FFD, {5'd0, 2'(k), 1'b1});
			for (int s = 0; s < 4; s++) begin
				a = {2'(s), 14'h0123};
				mem_read(a, stored_byte(expected_addr(a)));
			end
		end
		mem_cycle(16'h0040, 1'b1, 8'h3C);	// Slot 0 is RAM here
		mem_read(16'h0040, 8'h3C);
		io_write(16'h1FFD, 8'h04);
		mem_read(16'h0000, fill_byte(expected_addr(16'h0000)));
		io_write(16'h7FFD, 8'h10);
		mem_read(16'h0000, fill_byte(expected_addr(16'h0000)));
		finish_test();

		start_test("pentagon_ext");
		apply_reset(MODE_P1024);
		foreach (pent_data[i]) begin
			d = 8'($random(seed));
			io_write(16'h7FFD, pent_data[i]);
			mem_cycle(16'hC200, 1'b1, d);
			mem_read(16'hC200, d);
		end
		io_write(16'hEFF7, 8'h04);	// 128K-compatible, bit 5 locks again
		io_write(16'h7FFD, 8'h21);
		io_write(16'h7FFD, 8'h03);
		mem_read(16'hC200, stored_byte(expected_addr(16'hC200)));
		finish_test();

		start_test("rom_protect");
		apply_reset(MODE_128K);
		mem_read(16'h0100, fill_byte(expected_addr(16'h0100)));
		req_before = sdram.req;
		@(negedge clk_sys);
		cpu = '{addr: 16'h0100, dout: 8'hA5, mreq: 1'b1, iorq: 1'b0, rd: 1'b0, wr: 1'b1, m1: 1'b0};
		repeat (4) @(negedge clk_sys);
		checks++;
		assert (sdram.req == req_before) else begin
			$display("ROM write in %s issued an SDRAM request", test_name);
			errors++;
		end
		cpu = CPU_IDLE;
		mem_read(16'h0100, fill_byte(expected_addr(16'h0100)));
		finish_test();

		$display("Tests %0d, failed %0d, checks %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, checks, errors, dut.u_sdram_port.u_sva.failures);
		if (errors == 0 && dut.u_sdram_port.u_sva.failures == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout after %0d cycles, a test did not finish", WATCHDOG_CYCLES);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
logic/zx_bus_pkg.sv
logic/zx_mem_pkg.sv
logic/paging_regs.sv
logic/addr_mapper.sv
logic/sdram_port.sv
logic/zx_memory_top.sv
sim/zx_memory_sva.sv
sim/tb_zx_memory.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the zx_memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_zx_memory --Mdir "$BUILD_DIR" -f compile.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$BUILD_DIR/Vtb_zx_memory" +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if grep -qF "*** TEST FAILED ***" "$LOG"; then
	exit 1
fi
exit 0
